// File: verilog/ipod_macros.svh
`ifndef IPOD_MACROS_SVH
`define IPOD_MACROS_SVH

// ======================================================================
// Sample and flash geometry
// ======================================================================
`define IPOD_SAMPLE_W      8
`define IPOD_INDEX_W       8
// Word address is the sample index without its low bit
`define IPOD_WORD_ADDR_W   7
`define IPOD_FLASH_DATA_W  32
// Clip of 256 samples
`define IPOD_LAST_INDEX    8'd255

// ======================================================================
// Sample period in CLK_50M cycles
// ======================================================================
`define IPOD_PERIOD_W        16
// About 22 kHz
`define IPOD_PERIOD_DEFAULT  16'd2272
`define IPOD_PERIOD_MIN      16'd256
`define IPOD_PERIOD_MAX      16'd8192
`define IPOD_PERIOD_STEP     16'd128

`define IPOD_HEX_DIGITS  6

// Upper-case ASCII key codes
`define IPOD_KEY_PLAY     8'h45
`define IPOD_KEY_PAUSE    8'h44
`define IPOD_KEY_FWD      8'h46
`define IPOD_KEY_BACK     8'h42
`define IPOD_KEY_RESTART  8'h52

`endif

// File: verilog/ipod_pkg.sv
`include "ipod_macros.svh"

package ipod_pkg;

  // Transport state from the keyboard decoder
  typedef struct packed {
    logic playing;
    logic forward;
    logic restart;
  } play_ctrl_t;

  // Single-cycle speed events
  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_cmd_t;

  // Flash read request
  typedef struct packed {
    logic                         read;
    logic [`IPOD_WORD_ADDR_W-1:0] address;
  } flash_req_t;

  // Flash response
  typedef struct packed {
    logic                          waitrequest;
    logic                          readdatavalid;
    logic [`IPOD_FLASH_DATA_W-1:0] readdata;
  } flash_rsp_t;

  // Output sample with one-cycle valid
  typedef struct packed {
    logic                      valid;
    logic [`IPOD_SAMPLE_W-1:0] data;
  } sample_t;

  // Active-low segments, digit 0 in the low field
  typedef struct packed {
    logic [`IPOD_HEX_DIGITS-1:0][6:0] digit;
  } hex_segs_t;

endpackage

// File: verilog/kbd_command.sv
`timescale 1ns/1ps
`include "ipod_macros.svh"

module kbd_command (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  logic [7:0]           kbd_ascii,
  input  logic                 kbd_valid,
  output ipod_pkg::play_ctrl_t play_ctrl
);

  logic [7:0] key_upper;

  // Clearing bit 5 folds lower case onto upper case
  assign key_upper = kbd_ascii & 8'hDF;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      play_ctrl.playing <= 1'b0;
      play_ctrl.forward <= 1'b1;
      play_ctrl.restart <= 1'b0;
    end
    else
    begin
      // Restart is a single-cycle pulse
      play_ctrl.restart <= 1'b0;
      if (kbd_valid)
      begin
        case (key_upper)
          `IPOD_KEY_PLAY:    play_ctrl.playing <= 1'b1;
          `IPOD_KEY_PAUSE:   play_ctrl.playing <= 1'b0;
          `IPOD_KEY_FWD:     play_ctrl.forward <= 1'b1;
          `IPOD_KEY_BACK:    play_ctrl.forward <= 1'b0;
          `IPOD_KEY_RESTART: play_ctrl.restart <= 1'b1;
          // Other codes are ignored
          default: ;
        endcase
      end
    end
  end

endmodule

// File: verilog/sample_rate_ctrl.sv
`timescale 1ns/1ps
`include "ipod_macros.svh"

module sample_rate_ctrl (
  input  logic                      CLK_50M,
  input  logic                      arst_n,
  input  ipod_pkg::speed_cmd_t      speed,
  input  logic                      playing,
  output logic                      tick,
  output logic [`IPOD_PERIOD_W-1:0] period
);

  logic [`IPOD_PERIOD_W-1:0] count;

  // ======================================================================
  // Period register
  // ======================================================================
  // Speed-up shortens the period and saturates at both ends
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      period <= `IPOD_PERIOD_DEFAULT;
    else if (speed.reset)
      period <= `IPOD_PERIOD_DEFAULT;
    else if (speed.up)
      period <= (period <= `IPOD_PERIOD_MIN + `IPOD_PERIOD_STEP) ?
                `IPOD_PERIOD_MIN : period - `IPOD_PERIOD_STEP;
    else if (speed.down)
      period <= (period >= `IPOD_PERIOD_MAX - `IPOD_PERIOD_STEP) ?
                `IPOD_PERIOD_MAX : period + `IPOD_PERIOD_STEP;
  end

  // ======================================================================
  // Sample tick
  // ======================================================================
  // Counts cycles since the last tick; held at zero while paused
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (!playing)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (count >= period - 1'b1)
    begin
      count <= '0;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

  period_in_range_a: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
      (period >= `IPOD_PERIOD_MIN) && (period <= `IPOD_PERIOD_MAX)
  );

endmodule

// File: verilog/flash_reader.sv
`timescale 1ns/1ps
`include "ipod_macros.svh"

module flash_reader (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  ipod_pkg::play_ctrl_t play_ctrl,
  input  logic                 tick,
  output ipod_pkg::flash_req_t flash_req,
  input  ipod_pkg::flash_rsp_t flash_rsp,
  output ipod_pkg::sample_t    sample
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT_DATA
  } state_t;

  state_t                       state;
  logic [`IPOD_INDEX_W-1:0]     index;
  logic [`IPOD_INDEX_W-1:0]     fetch_index;
  logic [`IPOD_INDEX_W-1:0]     next_index;
  logic                         restart_pending;
  logic                         apply_restart;
  logic                         start_fetch;
  logic                         read_q;
  logic [`IPOD_WORD_ADDR_W-1:0] addr_q;
  logic                         valid_q;
  logic [`IPOD_SAMPLE_W-1:0]    data_q;
  logic [`IPOD_SAMPLE_W-1:0]    picked_byte;

  // Ticks that arrive mid-fetch are dropped
  assign start_fetch   = (state == ST_IDLE) && tick && play_ctrl.playing;
  assign apply_restart = restart_pending || play_ctrl.restart;

  // Restart jumps to the start of the clip in the current direction
  always_comb
  begin
    if (apply_restart)
      fetch_index = play_ctrl.forward ? '0 : `IPOD_LAST_INDEX;
    else
      fetch_index = index;
  end

  always_comb
  begin
    if (play_ctrl.forward)
      next_index = (index == `IPOD_LAST_INDEX) ? '0 : index + 1'b1;
    else
      next_index = (index == '0) ? `IPOD_LAST_INDEX : index - 1'b1;
  end

  // Odd index takes the high half-word, upper byte of each half
  assign picked_byte = index[0] ?
    flash_rsp.readdata[`IPOD_FLASH_DATA_W-1 -: `IPOD_SAMPLE_W] :
    flash_rsp.readdata[`IPOD_FLASH_DATA_W/2-1 -: `IPOD_SAMPLE_W];

  // ======================================================================
  // Fetch FSM
  // ======================================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state           <= ST_IDLE;
      index           <= '0;
      restart_pending <= 1'b0;
      read_q          <= 1'b0;
      valid_q         <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      if (start_fetch)
        restart_pending <= 1'b0;
      else if (play_ctrl.restart)
        restart_pending <= 1'b1;

      case (state)
        ST_IDLE:
        begin
          if (start_fetch)
          begin
            index  <= fetch_index;
            read_q <= 1'b1;
            state  <= ST_REQ;
          end
        end
        ST_REQ:
        begin
          // Accepted once waitrequest is low
          if (!flash_rsp.waitrequest)
          begin
            read_q <= 1'b0;
            state  <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA:
        begin
          if (flash_rsp.readdatavalid)
          begin
            valid_q <= 1'b1;
            index   <= next_index;
            state   <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address and sample byte
  always_ff @(posedge CLK_50M)
  begin
    if (start_fetch)
      addr_q <= fetch_index[`IPOD_INDEX_W-1:1];
    if ((state == ST_WAIT_DATA) && flash_rsp.readdatavalid)
      data_q <= picked_byte;
  end

  assign flash_req.read    = read_q;
  assign flash_req.address = addr_q;
  assign sample.valid      = valid_q;
  assign sample.data       = data_q;

  req_stable_a: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
      (flash_req.read && flash_rsp.waitrequest) |=>
        (flash_req.read && $stable(flash_req.address))
  );

  no_data_in_idle_a: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
      (state == ST_IDLE) |-> !flash_rsp.readdatavalid
  );

endmodule

// File: verilog/hex_display.sv
`timescale 1ns/1ps
`include "ipod_macros.svh"

module hex_display (
  input  logic                      CLK_50M,
  input  logic                      arst_n,
  input  logic [`IPOD_PERIOD_W-1:0] period,
  output ipod_pkg::hex_segs_t       hex
);

  localparam int NIBBLES_W = 4 * `IPOD_HEX_DIGITS;

  logic [NIBBLES_W-1:0] nibbles;

  // Active low, segment a at bit 0 through g at bit 6
  function automatic logic [6:0] seg_encode(input logic [3:0] value);
    logic [6:0] segs;
    case (value)
      4'h0: segs = 7'b1000000;
      4'h1: segs = 7'b1111001;
      4'h2: segs = 7'b0100100;
      4'h3: segs = 7'b0110000;
      4'h4: segs = 7'b0011001;
      4'h5: segs = 7'b0010010;
      4'h6: segs = 7'b0000010;
      4'h7: segs = 7'b1111000;
      4'h8: segs = 7'b0000000;
      4'h9: segs = 7'b0010000;
      4'hA: segs = 7'b0001000;
      4'hB: segs = 7'b0000011;
      4'hC: segs = 7'b1000110;
      4'hD: segs = 7'b0100001;
      4'hE: segs = 7'b0000110;
      default: segs = 7'b0001110;
    endcase
    return segs;
  endfunction

  // Upper digits show leading zeros
  assign nibbles = {{(NIBBLES_W - `IPOD_PERIOD_W){1'b0}}, period};

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int d = 0; d < `IPOD_HEX_DIGITS; d++)
        hex.digit[d] <= seg_encode(4'h0);
    end
    else
    begin
      for (int d = 0; d < `IPOD_HEX_DIGITS; d++)
        hex.digit[d] <= seg_encode(nibbles[4*d +: 4]);
    end
  end

endmodule

// File: verilog/simple_ipod.sv
`timescale 1ns/1ps
`include "ipod_macros.svh"

module simple_ipod (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  logic [7:0]           kbd_ascii,
  input  logic                 kbd_valid,
  input  ipod_pkg::speed_cmd_t speed_cmd,
  output ipod_pkg::flash_req_t flash_req,
  input  ipod_pkg::flash_rsp_t flash_rsp,
  output ipod_pkg::sample_t    sample,
  output ipod_pkg::hex_segs_t  hex
);

  ipod_pkg::play_ctrl_t      play_ctrl;
  logic                      tick;
  logic [`IPOD_PERIOD_W-1:0] period;

  // ======================================================================
  // Transport and sample rate
  // ======================================================================
  kbd_command kbd_command_i (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .play_ctrl (play_ctrl)
  );

  sample_rate_ctrl sample_rate_ctrl_i (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .speed   (speed_cmd),
    .playing (play_ctrl.playing),
    .tick    (tick),
    .period  (period)
  );

  // ======================================================================
  // Flash fetch and display
  // ======================================================================
  flash_reader flash_reader_i (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .play_ctrl (play_ctrl),
    .tick      (tick),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp),
    .sample    (sample)
  );

  // Shows the current period in hex
  hex_display hex_display_i (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .period  (period),
    .hex     (hex)
  );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic CLK_50M
);

  initial
  begin
    CLK_50M = 1'b0;
    forever
      #(PERIOD_NS / 2) CLK_50M = ~CLK_50M;
  end

endmodule

// File: testbench/simple_ipod_tb.sv
`timescale 1ns/1ps
`include "ipod_macros.svh"

module simple_ipod_tb;

  localparam int SAMPLES_REQUESTED = 300 + 20 + 13 + 6;
  localparam int TIMEOUT_CYCLES = SAMPLES_REQUESTED * int'(`IPOD_PERIOD_MAX) + 10000;
  // Standard active-low font with segment a in bit 0
  localparam logic [6:0] SEG_FONT [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
    7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
  // Fields are {up, down, reset}
  localparam ipod_pkg::speed_cmd_t SPEED_UP    = 3'b100;
  localparam ipod_pkg::speed_cmd_t SPEED_DOWN  = 3'b010;
  localparam ipod_pkg::speed_cmd_t SPEED_RESET = 3'b001;
  localparam ipod_pkg::speed_cmd_t SPEED_ALL   = 3'b111;

  logic                 CLK_50M;
  logic                 arst_n = 1'b0;
  logic [7:0]           kbd_ascii = 8'h00;
  logic                 kbd_valid = 1'b0;
  ipod_pkg::speed_cmd_t speed_cmd = '0;
  ipod_pkg::flash_req_t flash_req;
  ipod_pkg::flash_rsp_t flash_rsp = '0;
  ipod_pkg::sample_t    sample;
  ipod_pkg::hex_segs_t  hex;

  // Expected transport state
  logic [7:0]  model_index = 8'd0;
  logic        model_forward = 1'b1;
  logic        model_restart = 1'b0;
  logic [15:0] model_period = `IPOD_PERIOD_DEFAULT;
  int          sample_count = 0;
  int          last_valid_cycle = 0;
  int          cycle_count = 0;
  int          waits_left = 0;
  int          latency_left = 0;
  int          next_waits;
  int          first_cycle;
  int          paused_count;
  logic [6:0]  accepted_addr = '0;

  tb_clock_gen clock_gen_i (.CLK_50M(CLK_50M));

  simple_ipod simple_ipod_i (.*);

  // ======================================================================
  // Reference functions
  // ======================================================================
  // Sample value stored in the clip for each index
  function automatic logic [7:0] sample_value(input logic [7:0] index);
    return index * 8'd37 + 8'd11;
  endfunction

  // Upper byte of each half-word holds a sample and the lower byte its complement
  function automatic logic [31:0] word_value(input logic [6:0] word_addr);
    logic [7:0] high_byte;
    logic [7:0] low_byte;
    high_byte = sample_value({word_addr, 1'b1});
    low_byte  = sample_value({word_addr, 1'b0});
    return {high_byte, ~high_byte, low_byte, ~low_byte};
  endfunction

  function automatic logic [7:0] step_index(input logic [7:0] index, input logic forward);
    if (forward)
      return (index == `IPOD_LAST_INDEX) ? 8'd0 : index + 8'd1;
    else
      return (index == 8'd0) ? `IPOD_LAST_INDEX : index - 8'd1;
  endfunction

  function automatic logic [15:0] period_after(input logic [15:0] period,
                                                input ipod_pkg::speed_cmd_t cmd);
    int next_period;
    next_period = int'(period);
    if (cmd.reset)
      next_period = int'(`IPOD_PERIOD_DEFAULT);
    else if (cmd.up)
      next_period = next_period - int'(`IPOD_PERIOD_STEP);
    else if (cmd.down)
      next_period = next_period + int'(`IPOD_PERIOD_STEP);
    if (next_period < int'(`IPOD_PERIOD_MIN))
      next_period = int'(`IPOD_PERIOD_MIN);
    if (next_period > int'(`IPOD_PERIOD_MAX))
      next_period = int'(`IPOD_PERIOD_MAX);
    return 16'(next_period);
  endfunction

  function automatic ipod_pkg::hex_segs_t segments_of(input logic [15:0] period);
    ipod_pkg::hex_segs_t segs;
    logic [23:0] nibbles;
    nibbles = {8'h00, period};
    for (int d = 0; d < `IPOD_HEX_DIGITS; d++)
      segs.digit[d] = SEG_FONT[nibbles[4*d +: 4]];
    return segs;
  endfunction

  // ======================================================================
  // Checks
  // ======================================================================
  task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic check_sample(input ipod_pkg::sample_t actual,
                              input ipod_pkg::sample_t expected);
    if (actual !== expected)
    begin
      $display("FAIL at %t: sample expected %h, got %h", $time, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_hex(input string name, input ipod_pkg::hex_segs_t actual,
                           input ipod_pkg::hex_segs_t expected);
    if (actual !== expected)
    begin
      $display("FAIL at %t: %s expected %h, got %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  // Address only matters while read is high
  task automatic check_flash_req(input ipod_pkg::flash_req_t actual,
                                 input ipod_pkg::flash_req_t expected);
    if (actual.read !== expected.read ||
        (expected.read && actual.address !== expected.address))
    begin
      $display("FAIL at %t: flash_req expected %h, got %h", $time, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_range(input string name, input int actual, input int low,
                             input int high);
    if (actual < low || actual > high)
    begin
      $display("FAIL at %t: %s expected %0d to %0d, got %0d", $time, name, low, high, actual);
      stop_with_failure();
    end
  endtask

  // ======================================================================
  // Stimulus helpers
  // ======================================================================
  task automatic send_key(input logic [7:0] code);
    @(posedge CLK_50M);
    kbd_ascii <= code;
    kbd_valid <= 1'b1;
    case (code)
      `IPOD_KEY_FWD, `IPOD_KEY_FWD | 8'h20:         model_forward = 1'b1;
      `IPOD_KEY_BACK, `IPOD_KEY_BACK | 8'h20:       model_forward = 1'b0;
      `IPOD_KEY_RESTART, `IPOD_KEY_RESTART | 8'h20: model_restart = 1'b1;
      default: ;
    endcase
    @(posedge CLK_50M);
    kbd_valid <= 1'b0;
  endtask

  // Hex still old one cycle later and new after two
  task automatic pulse_speed(input ipod_pkg::speed_cmd_t cmd);
    ipod_pkg::hex_segs_t old_segs;
    old_segs = segments_of(model_period);
    @(posedge CLK_50M);
    speed_cmd <= cmd;
    model_period = period_after(model_period, cmd);
    @(posedge CLK_50M);
    speed_cmd <= '0;
    @(negedge CLK_50M);
    check_hex("hex one cycle after speed pulse", hex, old_segs);
    @(negedge CLK_50M);
    check_hex("hex", hex, segments_of(model_period));
  endtask

  task automatic wait_samples(input int count);
    int target;
    target = sample_count + count;
    while (sample_count < target)
      @(posedge CLK_50M);
  endtask

  // ======================================================================
  // Flash model, compare process and timeout
  // ======================================================================
  always @(posedge CLK_50M)
  begin
    if (!arst_n)
    begin
      flash_rsp    <= '0;
      waits_left   <= 0;
      latency_left <= 0;
    end
    else
    begin
      flash_rsp.readdatavalid <= 1'b0;
      if (flash_req.read && !flash_rsp.waitrequest)
      begin
        accepted_addr <= flash_req.address;
        latency_left  <= 1 + int'($urandom % 4);
        next_waits = int'($urandom % 4);
        waits_left            <= next_waits;
        flash_rsp.waitrequest <= (next_waits > 0);
      end
      else if (flash_req.read)
      begin
        waits_left            <= waits_left - 1;
        flash_rsp.waitrequest <= (waits_left > 1);
      end
      if (latency_left == 1)
      begin
        flash_rsp.readdatavalid <= 1'b1;
        flash_rsp.readdata      <= word_value(accepted_addr);
      end
      if (latency_left > 0)
        latency_left <= latency_left - 1;
    end
  end

  always @(negedge CLK_50M)
  begin
    if (arst_n && sample.valid)
    begin
      if (model_restart)
      begin
        model_index   = model_forward ? 8'd0 : `IPOD_LAST_INDEX;
        model_restart = 1'b0;
      end
      check_sample(sample, {1'b1, sample_value(model_index)});
      model_index      = step_index(model_index, model_forward);
      sample_count     = sample_count + 1;
      last_valid_cycle = cycle_count;
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish");
      stop_with_failure();
    end
  end

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial
  begin
    void'($urandom(12162));
    $timeformat(-9, 0, " ns", 0);
    repeat (2) @(posedge CLK_50M);
    arst_n <= 1'b1;

    // Idle after reset
    repeat (3 * `IPOD_PERIOD_DEFAULT)
    begin
      @(negedge CLK_50M);
      check_flash_req(flash_req, '0);
    end
    check_hex("hex", hex, segments_of(`IPOD_PERIOD_DEFAULT));
    check_range("samples while idle", sample_count, 0, 0);

    // Speed steps, both clamps, reset priority
    pulse_speed(SPEED_UP);
    pulse_speed(SPEED_DOWN);
    repeat (70) pulse_speed(SPEED_DOWN);
    pulse_speed(SPEED_ALL);
    repeat (18) pulse_speed(SPEED_UP);
    pulse_speed(SPEED_RESET);
    repeat (18) pulse_speed(SPEED_UP);

    // Forward play at the minimum period wraps past 255
    send_key(`IPOD_KEY_PLAY);
    send_key(`IPOD_KEY_FWD | 8'h20);
    wait_samples(100);
    send_key(8'h78);
    wait_samples(200);

    // Spacing over 20 samples
    repeat (4) pulse_speed(SPEED_DOWN);
    wait_samples(1);
    first_cycle = last_valid_cycle;
    wait_samples(19);
    check_range("sample spacing", last_valid_cycle - first_cycle,
      19 * int'(model_period) - 8, 19 * int'(model_period) + 8);

    // Restart forward and then run backward through 0
    send_key(`IPOD_KEY_RESTART);
    wait_samples(3);
    send_key(`IPOD_KEY_BACK | 8'h20);
    wait_samples(6);
    send_key(`IPOD_KEY_RESTART | 8'h20);
    wait_samples(4);

    // Pause with a fetch in flight and then resume
    while (flash_req.read !== 1'b1)
      @(posedge CLK_50M);
    paused_count = sample_count;
    send_key(`IPOD_KEY_PAUSE);
    repeat (3 * int'(model_period)) @(posedge CLK_50M);
    check_range("samples after pause", sample_count - paused_count, 1, 1);
    repeat (2 * int'(model_period))
    begin
      @(negedge CLK_50M);
      check_flash_req(flash_req, '0);
    end
    send_key(`IPOD_KEY_PLAY | 8'h20);
    wait_samples(5);

    if (sample_count == SAMPLES_REQUESTED)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      $display("FAIL at %t: sample count expected %0d, got %0d", $time,
        SAMPLES_REQUESTED, sample_count);
      stop_with_failure();
    end
  end

endmodule

// File: all.f
+incdir+verilog
verilog/ipod_pkg.sv
verilog/kbd_command.sv
verilog/sample_rate_ctrl.sv
verilog/flash_reader.sv
verilog/hex_display.sv
verilog/simple_ipod.sv
testbench/tb_clock_gen.sv
testbench/simple_ipod_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the simple_ipod testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module simple_ipod_tb -f all.f -o simple_ipod_sim

./obj_dir/simple_ipod_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
